//--- ooo_exec_pkg.sv
`default_nettype none

package ooo_exec_pkg;

	// datapath and tag widths
	localparam int DATA_W    = 16;
	localparam int PREG_W    = 6;
	localparam int NUM_PREG  = 64;
	localparam int ROB_IDX_W = 6;

	// register file port counts, two reads per lane
	localparam int NUM_RD = 6;
	localparam int NUM_WR = 3;

	localparam int SHAMT_W = $clog2(DATA_W);

	// multiplier retires MUL_STEP_W bits of op2 per iteration
	localparam int MUL_CYCLES = 4;
	localparam int MUL_STEP_W = DATA_W / MUL_CYCLES;
	localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);
	// issue edge to done, RF/EX + load + iterations + EX/WB
	localparam int MUL_LAT    = MUL_CYCLES + 2;

	typedef enum logic [2:0] {
		MODE_ADD  = 3'd0,
		MODE_SUB  = 3'd1,
		MODE_AND  = 3'd2,
		MODE_OR   = 3'd3,
		MODE_XOR  = 3'd4,
		MODE_SHL  = 3'd5,
		MODE_SHR  = 3'd6,
		MODE_PASS = 3'd7
	} alu_mode_e;

	typedef struct packed {
		logic                 vld;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PREG_W-1:0]    src1;
		logic [PREG_W-1:0]    src2;
		logic [PREG_W-1:0]    dst;
		logic                 reg_wrt;
		logic                 imm_vld;
		logic [DATA_W-1:0]    imm;
		logic                 ldi;
		logic                 inv_rt;
		alu_mode_e            mode;
	} issue_pkt_t;

	// op2 already resolved to the immediate where needed
	typedef struct packed {
		logic                 vld;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PREG_W-1:0]    dst;
		logic                 reg_wrt;
		logic                 ldi;
		logic                 inv_rt;
		alu_mode_e            mode;
		logic [DATA_W-1:0]    imm;
		logic [DATA_W-1:0]    op1;
		logic [DATA_W-1:0]    op2;
	} exec_req_t;

	typedef struct packed {
		logic                 vld;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic                 reg_wrt;
		logic [PREG_W-1:0]    dst;
		logic [DATA_W-1:0]    data;
	} wb_t;

endpackage

`default_nettype wire

//--- prf.sv
`timescale 1ns/1ps
`default_nettype none

module prf (
	input  logic                                                       clk,
	input  logic                                                       rst,
	input  logic [ooo_exec_pkg::NUM_RD-1:0][ooo_exec_pkg::PREG_W-1:0] rd_addr,
	output logic [ooo_exec_pkg::NUM_RD-1:0][ooo_exec_pkg::DATA_W-1:0] rd_data,
	input  ooo_exec_pkg::wb_t                                          alu1_wb,
	input  ooo_exec_pkg::wb_t                                          alu2_wb,
	input  ooo_exec_pkg::wb_t                                          mult_wb
);

	logic [ooo_exec_pkg::DATA_W-1:0] regs [ooo_exec_pkg::NUM_PREG];

	ooo_exec_pkg::wb_t [ooo_exec_pkg::NUM_WR-1:0] wr;
	logic [ooo_exec_pkg::NUM_WR-1:0]              wr_en;

	assign wr = {mult_wb, alu2_wb, alu1_wb};

	always_comb begin
		for (int p = 0; p < ooo_exec_pkg::NUM_WR; p++) begin
			wr_en[p] = wr[p].vld && wr[p].reg_wrt;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ooo_exec_pkg::NUM_PREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int p = 0; p < ooo_exec_pkg::NUM_WR; p++) begin
				if (wr_en[p]) begin
					regs[wr[p].dst] <= wr[p].data;
				end
			end
		end
	end

	// write data in flight this cycle overrides the array
	always_comb begin
		for (int r = 0; r < ooo_exec_pkg::NUM_RD; r++) begin
			rd_data[r] = regs[rd_addr[r]];
			for (int p = 0; p < ooo_exec_pkg::NUM_WR; p++) begin
				if (wr_en[p] && wr[p].dst == rd_addr[r]) begin
					rd_data[r] = wr[p].data;
				end
			end
		end
	end

	// renaming never hands one preg to two lanes finishing together
	wr_port_conflict: assert property (@(posedge clk) disable iff (rst)
		!(wr_en[0] && wr_en[1] && wr[0].dst == wr[1].dst) &&
		!(wr_en[0] && wr_en[2] && wr[0].dst == wr[2].dst) &&
		!(wr_en[1] && wr_en[2] && wr[1].dst == wr[2].dst))
		else $error("prf: two write ports hit the same preg");

endmodule

`default_nettype wire

//--- operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
	input  logic                     clk,
	input  logic                     rst,
	input  ooo_exec_pkg::issue_pkt_t alu1_issue,
	input  ooo_exec_pkg::issue_pkt_t alu2_issue,
	input  ooo_exec_pkg::issue_pkt_t mult_issue,
	input  ooo_exec_pkg::wb_t        alu1_wb,
	input  ooo_exec_pkg::wb_t        alu2_wb,
	input  ooo_exec_pkg::wb_t        mult_wb,
	output ooo_exec_pkg::exec_req_t  alu1_req,
	output ooo_exec_pkg::exec_req_t  alu2_req,
	output ooo_exec_pkg::exec_req_t  mult_req
);

	logic [ooo_exec_pkg::NUM_RD-1:0][ooo_exec_pkg::PREG_W-1:0] rd_addr;
	logic [ooo_exec_pkg::NUM_RD-1:0][ooo_exec_pkg::DATA_W-1:0] rd_data;

	ooo_exec_pkg::exec_req_t alu1_nxt;
	ooo_exec_pkg::exec_req_t alu2_nxt;
	ooo_exec_pkg::exec_req_t mult_nxt;

	function automatic ooo_exec_pkg::exec_req_t resolve(
		input ooo_exec_pkg::issue_pkt_t        pkt,
		input logic [ooo_exec_pkg::DATA_W-1:0] d1,
		input logic [ooo_exec_pkg::DATA_W-1:0] d2
	);
		ooo_exec_pkg::exec_req_t req;
		req.vld     = pkt.vld;
		req.rob_idx = pkt.rob_idx;
		req.dst     = pkt.dst;
		req.reg_wrt = pkt.reg_wrt;
		req.ldi     = pkt.ldi;
		req.inv_rt  = pkt.inv_rt;
		req.mode    = pkt.mode;
		req.imm     = pkt.imm;
		req.op1     = d1;
		req.op2     = pkt.imm_vld ? pkt.imm : d2;
		return req;
	endfunction

	// two read ports per lane, src1 on the even port
	assign rd_addr = {mult_issue.src2, mult_issue.src1,
			alu2_issue.src2, alu2_issue.src1,
			alu1_issue.src2, alu1_issue.src1};

	prf u_prf (
		.clk(clk),
		.rst(rst),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.alu1_wb(alu1_wb),
		.alu2_wb(alu2_wb),
		.mult_wb(mult_wb)
	);

	assign alu1_nxt = resolve(alu1_issue, rd_data[0], rd_data[1]);
	assign alu2_nxt = resolve(alu2_issue, rd_data[2], rd_data[3]);
	assign mult_nxt = resolve(mult_issue, rd_data[4], rd_data[5]);

	// RF/EX register
	always_ff @(posedge clk) begin
		alu1_req <= alu1_nxt;
		alu2_req <= alu2_nxt;
		mult_req <= mult_nxt;
		if (rst) begin
			alu1_req.vld <= 1'b0;
			alu2_req.vld <= 1'b0;
			mult_req.vld <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  ooo_exec_pkg::exec_req_t req,
	output ooo_exec_pkg::wb_t       done
);

	logic [ooo_exec_pkg::DATA_W-1:0] op2;
	logic [ooo_exec_pkg::DATA_W-1:0] result;

	assign op2 = req.inv_rt ? ~req.op2 : req.op2;

	always_comb begin
		case (req.mode)
			ooo_exec_pkg::MODE_ADD:  result = req.op1 + op2;
			ooo_exec_pkg::MODE_SUB:  result = req.op1 - op2;
			ooo_exec_pkg::MODE_AND:  result = req.op1 & op2;
			ooo_exec_pkg::MODE_OR:   result = req.op1 | op2;
			ooo_exec_pkg::MODE_XOR:  result = req.op1 ^ op2;
			ooo_exec_pkg::MODE_SHL:  result = req.op1 << op2[ooo_exec_pkg::SHAMT_W-1:0];
			ooo_exec_pkg::MODE_SHR:  result = req.op1 >> op2[ooo_exec_pkg::SHAMT_W-1:0];
			ooo_exec_pkg::MODE_PASS: result = req.op1;
			default:                 result = req.op1;
		endcase
		// load immediate bypasses the mode result
		if (req.ldi) begin
			result = req.imm;
		end
	end

	// EX/WB register
	always_ff @(posedge clk) begin
		done.rob_idx <= req.rob_idx;
		done.dst     <= req.dst;
		done.data    <= result;
		if (rst) begin
			done.vld     <= 1'b0;
			done.reg_wrt <= 1'b0;
		end else begin
			done.vld     <= req.vld;
			done.reg_wrt <= req.vld && req.reg_wrt;
		end
	end

endmodule

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  ooo_exec_pkg::exec_req_t req,
	output logic                    busy,
	output ooo_exec_pkg::wb_t       done
);

	logic [ooo_exec_pkg::MUL_CNT_W-1:0] cnt;
	logic                               last;

	logic [ooo_exec_pkg::DATA_W-1:0]    acc;
	logic [ooo_exec_pkg::DATA_W-1:0]    mcand;
	logic [ooo_exec_pkg::DATA_W-1:0]    mplier;
	logic [ooo_exec_pkg::DATA_W-1:0]    partial;

	logic [ooo_exec_pkg::ROB_IDX_W-1:0] tag_rob_idx;
	logic [ooo_exec_pkg::PREG_W-1:0]    tag_dst;
	logic                               tag_reg_wrt;

	// all iterations done, retire on this edge
	assign last = busy && (cnt == ooo_exec_pkg::MUL_CNT_W'(ooo_exec_pkg::MUL_CYCLES));

	// low product bits only, upper partial bits fall off
	assign partial = mcand * mplier[ooo_exec_pkg::MUL_STEP_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (req.vld) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (last) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req.vld) begin
			acc         <= '0;
			mcand       <= req.op1;
			mplier      <= req.inv_rt ? ~req.op2 : req.op2;
			tag_rob_idx <= req.rob_idx;
			tag_dst     <= req.dst;
			tag_reg_wrt <= req.reg_wrt;
		end else if (busy && !last) begin
			acc    <= acc + partial;
			mcand  <= mcand << ooo_exec_pkg::MUL_STEP_W;
			mplier <= mplier >> ooo_exec_pkg::MUL_STEP_W;
		end
	end

	// EX/WB register, one-cycle completion
	always_ff @(posedge clk) begin
		done.rob_idx <= tag_rob_idx;
		done.dst     <= tag_dst;
		done.data    <= acc;
		if (rst) begin
			done.vld     <= 1'b0;
			done.reg_wrt <= 1'b0;
		end else begin
			done.vld     <= last;
			done.reg_wrt <= last && tag_reg_wrt;
		end
	end

	// issue must honour mult_free
	req_while_busy: assert property (@(posedge clk) disable iff (rst)
		req.vld |-> !busy)
		else $error("mul_unit: request accepted while busy");

endmodule

`default_nettype wire

//--- exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  ooo_exec_pkg::exec_req_t alu1_req,
	input  ooo_exec_pkg::exec_req_t alu2_req,
	input  ooo_exec_pkg::exec_req_t mult_req,
	output logic                    mult_free,
	output ooo_exec_pkg::wb_t       alu1_done,
	output ooo_exec_pkg::wb_t       alu2_done,
	output ooo_exec_pkg::wb_t       mult_done
);

	logic mul_busy;

	alu_unit u_alu1 (
		.clk(clk),
		.rst(rst),
		.req(alu1_req),
		.done(alu1_done)
	);

	alu_unit u_alu2 (
		.clk(clk),
		.rst(rst),
		.req(alu2_req),
		.done(alu2_done)
	);

	mul_unit u_mul (
		.clk(clk),
		.rst(rst),
		.req(mult_req),
		.busy(mul_busy),
		.done(mult_done)
	);

	// slot held from the RF/EX stage until the multiplier retires
	assign mult_free = !mult_req.vld && !mul_busy;

	// the slot reopens in the cycle the product retires
	mult_free_on_done: assert property (@(posedge clk) disable iff (rst)
		mult_done.vld |-> mult_free)
		else $error("exec_stage: mult_free low while mult_done is valid");

endmodule

`default_nettype wire

//--- ooo_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_exec_top (
	input  logic                     clk,
	input  logic                     rst,
	input  ooo_exec_pkg::issue_pkt_t alu1_issue,
	input  ooo_exec_pkg::issue_pkt_t alu2_issue,
	input  ooo_exec_pkg::issue_pkt_t mult_issue,
	output logic                     mult_free,
	output ooo_exec_pkg::wb_t        alu1_done,
	output ooo_exec_pkg::wb_t        alu2_done,
	output ooo_exec_pkg::wb_t        mult_done
);

	// RF/EX stage outputs
	ooo_exec_pkg::exec_req_t alu1_req;
	ooo_exec_pkg::exec_req_t alu2_req;
	ooo_exec_pkg::exec_req_t mult_req;

	operand_fetch u_operand_fetch (
		.clk(clk),
		.rst(rst),
		.alu1_issue(alu1_issue),
		.alu2_issue(alu2_issue),
		.mult_issue(mult_issue),
		.alu1_wb(alu1_done),
		.alu2_wb(alu2_done),
		.mult_wb(mult_done),
		.alu1_req(alu1_req),
		.alu2_req(alu2_req),
		.mult_req(mult_req)
	);

	exec_stage u_exec_stage (
		.clk(clk),
		.rst(rst),
		.alu1_req(alu1_req),
		.alu2_req(alu2_req),
		.mult_req(mult_req),
		.mult_free(mult_free),
		.alu1_done(alu1_done),
		.alu2_done(alu2_done),
		.mult_done(mult_done)
	);

endmodule

`default_nettype wire

//--- tb_ooo_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_exec_top;

	localparam int N_FILL  = ooo_exec_pkg::NUM_PREG / 2;
	localparam int N_ALU   = 300;
	localparam int N_MUL   = 40;
	localparam int N_CHAIN = 120;
	localparam int N_NOWR  = 120;
	// upper bound on operations issued over all tests
	localparam int MAX_OPS = 1 + 2 * N_FILL + 2 * N_ALU + 2 * N_CHAIN + 2 * N_NOWR
		+ N_MUL * (1 + 2 * (ooo_exec_pkg::MUL_LAT + 1));
	localparam int CYCLE_LIMIT = MAX_OPS * ooo_exec_pkg::MUL_LAT + 200;

	typedef struct packed {
		logic [1:0]        lane;
		logic [31:0]       due;
		ooo_exec_pkg::wb_t wb;
	} exp_t;

	logic                     clk;
	logic                     rst;
	ooo_exec_pkg::issue_pkt_t alu1_issue;
	ooo_exec_pkg::issue_pkt_t alu2_issue;
	ooo_exec_pkg::issue_pkt_t mult_issue;
	logic                     mult_free;
	ooo_exec_pkg::wb_t        alu1_done;
	ooo_exec_pkg::wb_t        alu2_done;
	ooo_exec_pkg::wb_t        mult_done;

	logic [ooo_exec_pkg::DATA_W-1:0]    model_rf [ooo_exec_pkg::NUM_PREG];
	bit                                 inflight [ooo_exec_pkg::NUM_PREG];
	exp_t                               exp_q [$];
	int                                 cyc = 0;
	int                                 errors;
	int                                 checks;
	int                                 ops;
	logic [ooo_exec_pkg::ROB_IDX_W-1:0] rob_cnt;
	bit                                 mul_pending;
	int                                 mul_due;
	bit                                 fresh_vld;
	logic [ooo_exec_pkg::PREG_W-1:0]    fresh_dst;
	bit                                 nowr_vld;
	logic [ooo_exec_pkg::PREG_W-1:0]    nowr_dst;

	ooo_exec_top dut (
		.clk(clk),
		.rst(rst),
		.alu1_issue(alu1_issue),
		.alu2_issue(alu2_issue),
		.mult_issue(mult_issue),
		.mult_free(mult_free),
		.alu1_done(alu1_done),
		.alu2_done(alu2_done),
		.mult_done(mult_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, completions never drained", cyc);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic ooo_exec_pkg::wb_t lane_done(input int l);
		case (l)
			0:       return alu1_done;
			1:       return alu2_done;
			default: return mult_done;
		endcase
	endfunction

	function automatic string lane_name(input int l);
		case (l)
			0:       return "alu1_done";
			1:       return "alu2_done";
			default: return "mult_done";
		endcase
	endfunction

	// reference result from the architectural rules
	function automatic logic [15:0] expect_data(input ooo_exec_pkg::issue_pkt_t p, input bit is_mul);
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] prod;
		a = model_rf[p.src1];
		b = p.imm_vld ? p.imm : model_rf[p.src2];
		if (p.inv_rt) begin
			b = ~b;
		end
		if (is_mul) begin
			prod = a * b;
			return prod[15:0];
		end
		if (p.ldi) begin
			return p.imm;
		end
		case (p.mode)
			ooo_exec_pkg::MODE_ADD: return a + b;
			ooo_exec_pkg::MODE_SUB: return a - b;
			ooo_exec_pkg::MODE_AND: return a & b;
			ooo_exec_pkg::MODE_OR:  return a | b;
			ooo_exec_pkg::MODE_XOR: return a ^ b;
			ooo_exec_pkg::MODE_SHL: return a << b[3:0];
			ooo_exec_pkg::MODE_SHR: return a >> b[3:0];
			default:                return a;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s got %h expected %h at cycle %0d", name, got, exp, cyc);
			errors++;
		end
	endtask

	// compare done ports with the queue, then retire into the model
	task automatic retire_and_check();
		ooo_exec_pkg::wb_t got;
		exp_t              e;
		int                idx;
		bit                exp_free;
		exp_free = !mul_pending || (mul_due == cyc);
		check_val("mult_free", mult_free, exp_free);
		fresh_vld = 1'b0;
		for (int l = 0; l < 3; l++) begin
			got = lane_done(l);
			idx = -1;
			for (int i = 0; i < exp_q.size(); i++) begin
				if (exp_q[i].lane == l && exp_q[i].due == cyc) begin
					idx = i;
				end
			end
			if (idx < 0) begin
				check_val({lane_name(l), ".vld"}, got.vld, 1'b0);
			end else begin
				e = exp_q[idx];
				exp_q.delete(idx);
				check_val({lane_name(l), ".vld"}, got.vld, 1'b1);
				check_val({lane_name(l), ".rob_idx"}, got.rob_idx, e.wb.rob_idx);
				check_val({lane_name(l), ".reg_wrt"}, got.reg_wrt, e.wb.reg_wrt);
				check_val({lane_name(l), ".dst"}, got.dst, e.wb.dst);
				check_val({lane_name(l), ".data"}, got.data, e.wb.data);
				if (e.wb.reg_wrt) begin
					model_rf[e.wb.dst] = e.wb.data;
					inflight[e.wb.dst] = 1'b0;
					fresh_vld = 1'b1;
					fresh_dst = e.wb.dst;
				end else begin
					nowr_vld = 1'b1;
					nowr_dst = e.wb.dst;
				end
				if (l == 2) begin
					mul_pending = 1'b0;
				end
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		alu1_issue = '0;
		alu2_issue = '0;
		mult_issue = '0;
		retire_and_check();
	endtask

	function automatic int pick_src();
		int r;
		for (int t = 0; t < 8; t++) begin
			r = $urandom % ooo_exec_pkg::NUM_PREG;
			if (!inflight[r]) begin
				return r;
			end
		end
		return -1;
	endfunction

	function automatic int pick_dst();
		int r;
		for (int t = 0; t < 256; t++) begin
			r = $urandom % ooo_exec_pkg::NUM_PREG;
			if (!inflight[r]) begin
				return r;
			end
		end
		return 0;
	endfunction

	task automatic make_alu_pkt(output ooo_exec_pkg::issue_pkt_t p, output bit ok);
		int s1;
		int s2;
		int d;
		s1 = pick_src();
		s2 = pick_src();
		d = pick_dst();
		ok = (s1 >= 0) && (s2 >= 0);
		p = '0;
		p.vld = 1'b1;
		p.rob_idx = rob_cnt;
		p.src1 = s1[ooo_exec_pkg::PREG_W-1:0];
		p.src2 = s2[ooo_exec_pkg::PREG_W-1:0];
		p.dst = d[ooo_exec_pkg::PREG_W-1:0];
		p.reg_wrt = 1'b1;
		p.imm_vld = $urandom % 2;
		p.imm = $urandom;
		p.ldi = ($urandom % 8) == 0;
		p.inv_rt = $urandom % 2;
		p.mode = ooo_exec_pkg::alu_mode_e'($urandom % 8);
	endtask

	task automatic issue_on(input int l, input ooo_exec_pkg::issue_pkt_t p);
		exp_t e;
		e.lane = l;
		e.wb.vld = 1'b1;
		e.wb.rob_idx = p.rob_idx;
		e.wb.reg_wrt = p.reg_wrt;
		e.wb.dst = p.dst;
		e.wb.data = expect_data(p, l == 2);
		// sampled at the next edge, cyc + 1
		if (l == 2) begin
			e.due = cyc + 1 + ooo_exec_pkg::MUL_LAT;
			mul_pending = 1'b1;
			mul_due = e.due;
		end else begin
			e.due = cyc + 2;
		end
		exp_q.push_back(e);
		if (p.reg_wrt) begin
			inflight[p.dst] = 1'b1;
		end
		case (l)
			0:       alu1_issue = p;
			1:       alu2_issue = p;
			default: mult_issue = p;
		endcase
		ops++;
		rob_cnt++;
	endtask

	task automatic drain();
		next_cycle();
		while (exp_q.size() != 0 || mul_pending) begin
			next_cycle();
		end
		next_cycle();
	endtask

	task automatic report_test(input string name, input int err0);
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	initial begin
		ooo_exec_pkg::issue_pkt_t p;
		bit                       ok;
		int                       err0;
		int                       n;
		void'($urandom(40876));
		rst = 1'b1;
		alu1_issue = '0;
		alu2_issue = '0;
		mult_issue = '0;
		rob_cnt = '0;
		errors = 0;
		checks = 0;
		ops = 0;
		mul_pending = 1'b0;
		nowr_vld = 1'b0;
		for (int i = 0; i < ooo_exec_pkg::NUM_PREG; i++) begin
			model_rf[i] = '0;
			inflight[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset state, then add of two unwritten registers
		err0 = errors;
		next_cycle();
		p = '0;
		p.vld = 1'b1;
		p.rob_idx = rob_cnt;
		p.src1 = 7;
		p.src2 = 9;
		p.dst = 3;
		p.reg_wrt = 1'b1;
		p.mode = ooo_exec_pkg::MODE_ADD;
		issue_on(0, p);
		drain();
		report_test("reset", err0);

		err0 = errors;
		for (int i = 0; i < N_FILL; i++) begin
			next_cycle();
			p = '0;
			p.vld = 1'b1;
			p.reg_wrt = 1'b1;
			p.ldi = 1'b1;
			p.rob_idx = rob_cnt;
			p.dst = 2 * i;
			p.imm = $urandom;
			issue_on(0, p);
			p.rob_idx = rob_cnt;
			p.dst = 2 * i + 1;
			p.imm = $urandom;
			issue_on(1, p);
		end
		drain();
		report_test("load_immediate", err0);

		err0 = errors;
		for (int i = 0; i < N_ALU; i++) begin
			next_cycle();
			for (int l = 0; l < 2; l++) begin
				make_alu_pkt(p, ok);
				if (ok) begin
					issue_on(l, p);
				end
			end
		end
		drain();
		report_test("random_alu", err0);

		// multiplies only while the DUT reports a free slot
		err0 = errors;
		n = 0;
		while (n < N_MUL) begin
			next_cycle();
			if (mult_free) begin
				make_alu_pkt(p, ok);
				if (ok) begin
					p.ldi = 1'b0;
					issue_on(2, p);
					n++;
				end
			end
			for (int l = 0; l < 2; l++) begin
				make_alu_pkt(p, ok);
				if (ok) begin
					issue_on(l, p);
				end
			end
		end
		drain();
		report_test("multiply", err0);

		// source taken straight off a write port
		err0 = errors;
		for (int i = 0; i < N_CHAIN; i++) begin
			next_cycle();
			make_alu_pkt(p, ok);
			if (ok && fresh_vld) begin
				p.src1 = fresh_dst;
			end
			if (ok) begin
				issue_on(0, p);
			end
			make_alu_pkt(p, ok);
			if (ok && fresh_vld) begin
				p.src2 = fresh_dst;
				p.imm_vld = 1'b0;
			end
			if (ok) begin
				issue_on(1, p);
			end
		end
		drain();
		report_test("dependent_chain", err0);

		err0 = errors;
		for (int i = 0; i < N_NOWR; i++) begin
			next_cycle();
			make_alu_pkt(p, ok);
			p.reg_wrt = 1'b0;
			if (ok) begin
				issue_on(0, p);
			end
			make_alu_pkt(p, ok);
			if (nowr_vld && !inflight[nowr_dst]) begin
				p.src1 = nowr_dst;
				p.ldi = 1'b0;
				p.mode = ooo_exec_pkg::MODE_PASS;
			end
			if (ok) begin
				issue_on(1, p);
			end
		end
		drain();
		report_test("no_register_write", err0);

		$display("ops %0d, checks %0d, errors %0d", ops, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ooo_exec_top.f
ooo_exec_pkg.sv
prf.sv
operand_fetch.sv
alu_unit.sv
mul_unit.sv
exec_stage.sv
ooo_exec_top.sv
tb_ooo_exec_top.sv
